// ==== project.f ====
src/eth_tx_pkg.sv
src/frame_buffer.sv
src/crc32_engine.sv
src/tx_byte_counter.sv
src/tx_frame_fsm.sv
src/eth_tx_mac.sv
testbench/clock_gen.sv
testbench/tb_eth_tx_mac.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_eth_tx_mac \
    -o tb_eth_tx_mac || { echo "build failed"; exit 1; }
./obj_dir/tb_eth_tx_mac | tee sim.log
grep -q "^>>> PASS$" sim.log && exit 0 || exit 1

// ==== src/crc32_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc32_engine
(
    input  logic              clock,
    input  logic              reset,
    input  logic              crc_clear,
    input  logic              crc_update,
    input  logic              crc_shift,
    input  eth_tx_pkg::byte_t data_in,
    output eth_tx_pkg::byte_t fcs_byte
);
    import eth_tx_pkg::*;

    logic [31:0] crc_reg;

    // one byte, lsb first, reflected form
    function automatic logic [31:0] crc_next_byte(input logic [31:0] crc_in, input byte_t data);
        logic [31:0] crc;
        int          bit_idx;
        crc = crc_in ^ {24'h000000, data};
        for (bit_idx = 0; bit_idx < 8; bit_idx++)
        begin
            crc = {1'b0, crc[31:1]} ^ (CRC_POLY & {32{crc[0]}});
        end
        return crc;
    endfunction

    assign fcs_byte = ~crc_reg[7:0];            // fcs goes out low byte first

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            crc_reg <= CRC_INIT;
        end
        else if (crc_clear)
        begin
            crc_reg <= CRC_INIT;
        end
        else if (crc_update)
        begin
            crc_reg <= crc_next_byte(crc_reg, data_in);
        end
        else if (crc_shift)
        begin
            crc_reg <= {8'h00, crc_reg[31:8]};  // expose next fcs byte
        end
    end

endmodule

`default_nettype wire

// ==== src/eth_tx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_tx_mac
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     op_start,
    input  eth_tx_pkg::op_t          op_code,
    input  eth_tx_pkg::packet_addr_t op_address,
    input  eth_tx_pkg::byte_t        op_value,
    output logic                     op_done,
    output logic [16:0]              op_result,
    output eth_tx_pkg::byte_t        gmii_txd,
    output logic                     gmii_tx_en
);
    import eth_tx_pkg::*;

    packet_addr_t tx_address;
    packet_addr_t frame_length;
    packet_addr_t count_value;
    byte_t        tx_byte;
    byte_t        fcs_byte;
    logic         frame_sent;
    logic         frame_pending;
    logic         crc_clear;
    logic         crc_update;
    logic         crc_shift;
    logic         count_load;
    logic         count_last;

    frame_buffer buffer0
    (
        .clock         (clock),
        .reset         (reset),
        .op_start      (op_start),
        .op_code       (op_code),
        .op_address    (op_address),
        .op_value      (op_value),
        .op_done       (op_done),
        .op_result     (op_result),
        .tx_address    (tx_address),
        .frame_sent    (frame_sent),
        .frame_pending (frame_pending),
        .frame_length  (frame_length),
        .tx_byte       (tx_byte)
    );

    crc32_engine crc0
    (
        .clock      (clock),
        .reset      (reset),
        .crc_clear  (crc_clear),
        .crc_update (crc_update),
        .crc_shift  (crc_shift),
        .data_in    (tx_byte),                  // same byte the fsm puts on the line
        .fcs_byte   (fcs_byte)
    );

    tx_byte_counter counter0
    (
        .clock       (clock),
        .reset       (reset),
        .count_load  (count_load),
        .count_value (count_value),
        .count_last  (count_last)
    );

    tx_frame_fsm fsm0
    (
        .clock         (clock),
        .reset         (reset),
        .frame_pending (frame_pending),
        .frame_length  (frame_length),
        .tx_byte       (tx_byte),
        .fcs_byte      (fcs_byte),
        .count_last    (count_last),
        .tx_address    (tx_address),
        .frame_sent    (frame_sent),
        .crc_clear     (crc_clear),
        .crc_update    (crc_update),
        .crc_shift     (crc_shift),
        .count_load    (count_load),
        .count_value   (count_value),
        .gmii_txd      (gmii_txd),
        .gmii_tx_en    (gmii_tx_en)
    );

endmodule

`default_nettype wire

// ==== src/eth_tx_pkg.sv ====
`default_nettype none

package eth_tx_pkg;

    // ----------------------------------------
    // buffer geometry
    // ----------------------------------------
    localparam int BUFFER_SLOTS    = 32;
    localparam int SLOT_BITS       = 5;                     // log2 of BUFFER_SLOTS
    localparam int PACKET_SIZE     = 402;                   // max data bytes per frame
    localparam int ADDR_BITS       = 16;
    localparam int BYTE_INDEX_BITS = $clog2(PACKET_SIZE);   // index into one slot

    typedef logic [SLOT_BITS-1:0] slot_t;
    typedef logic [ADDR_BITS-1:0] packet_addr_t;
    typedef logic [7:0]           byte_t;
    typedef logic [1:0]           op_t;

    localparam op_t OP_WRITE      = 2'd0;
    localparam op_t OP_WRITE_LEN  = 2'd1;
    localparam op_t OP_WRITE_NEXT = 2'd2;

    // ----------------------------------------
    // framing
    // ----------------------------------------
    localparam byte_t PREAMBLE_BYTE = 8'h55;
    localparam byte_t SFD_BYTE      = 8'hD5;
    localparam int    PREAMBLE_LEN  = 7;
    localparam int    FCS_LEN       = 4;
    localparam int    IFG_LEN       = 12;

    localparam logic [31:0] CRC_POLY = 32'hEDB88320;        // reflected 802.3 polynomial
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    // transmit fsm encoding
    localparam int                  STATE_BITS  = 3;
    localparam logic [STATE_BITS-1:0] ST_IDLE     = 3'd0;
    localparam logic [STATE_BITS-1:0] ST_PREAMBLE = 3'd1;
    localparam logic [STATE_BITS-1:0] ST_SFD      = 3'd2;
    localparam logic [STATE_BITS-1:0] ST_DATA     = 3'd3;
    localparam logic [STATE_BITS-1:0] ST_FCS      = 3'd4;
    localparam logic [STATE_BITS-1:0] ST_GAP      = 3'd5;

endpackage

`default_nettype wire

// ==== src/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     op_start,
    input  eth_tx_pkg::op_t          op_code,
    input  eth_tx_pkg::packet_addr_t op_address,
    input  eth_tx_pkg::byte_t        op_value,
    output logic                     op_done,
    output logic [16:0]              op_result,
    input  eth_tx_pkg::packet_addr_t tx_address,
    input  logic                     frame_sent,
    output logic                     frame_pending,
    output eth_tx_pkg::packet_addr_t frame_length,
    output eth_tx_pkg::byte_t        tx_byte
);
    import eth_tx_pkg::*;

    byte_t        slot_mem [BUFFER_SLOTS][PACKET_SIZE];
    packet_addr_t slot_len [BUFFER_SLOTS];      // lengths of committed slots

    slot_t        fill_ptr;                     // slot the host is building
    slot_t        send_ptr;                     // slot the transmitter owns
    slot_t        fill_next;
    packet_addr_t fill_len;                     // running length of the fill slot
    packet_addr_t write_end;
    logic         write_ok;
    logic         do_write;
    logic         do_commit;

    assign fill_next = fill_ptr + slot_t'(1);
    assign write_ok  = (op_address < PACKET_SIZE);
    assign write_end = op_address + packet_addr_t'(1);
    assign do_write  = op_start && (op_code == OP_WRITE) && write_ok;
    assign do_commit = op_start && (op_code == OP_WRITE_NEXT) && (fill_next != send_ptr);

    // transmit side reads the send slot only
    assign frame_pending = (send_ptr != fill_ptr);
    assign frame_length  = slot_len[send_ptr];
    assign tx_byte       = slot_mem[send_ptr][tx_address[BYTE_INDEX_BITS-1:0]];

    // ----------------------------------------
    // storage
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (do_write)
        begin
            slot_mem[fill_ptr][op_address[BYTE_INDEX_BITS-1:0]] <= op_value;
        end
        if (do_commit)
        begin
            slot_len[fill_ptr] <= fill_len;     // freeze length at commit
        end
    end

    // ----------------------------------------
    // pointers and host operations
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            fill_ptr  <= '0;
            send_ptr  <= '0;
            fill_len  <= '0;
            op_done   <= 1'b0;
            op_result <= '0;
        end
        else
        begin
            op_done <= op_start;                // fixed one cycle answer

            if (frame_sent)
            begin
                send_ptr <= send_ptr + slot_t'(1);
            end

            if (op_start)
            begin
                case (op_code)
                    OP_WRITE:
                    begin
                        if (write_ok)
                        begin
                            if (write_end > fill_len)
                            begin
                                fill_len <= write_end;
                            end
                            op_result <= 17'd0;
                        end
                        else
                        begin
                            op_result <= 17'd1; // address past slot end
                        end
                    end
                    OP_WRITE_LEN:
                    begin
                        op_result <= {1'b0, fill_len};
                    end
                    OP_WRITE_NEXT:
                    begin
                        if (do_commit)
                        begin
                            fill_ptr  <= fill_next;
                            fill_len  <= '0;    // fresh slot starts empty
                            op_result <= 17'd0;
                        end
                        else
                        begin
                            op_result <= 17'd1; // ring full
                        end
                    end
                    default:
                    begin
                        op_result <= 17'd0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/tx_byte_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_byte_counter
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     count_load,
    input  eth_tx_pkg::packet_addr_t count_value,
    output logic                     count_last
);
    import eth_tx_pkg::*;

    packet_addr_t count;

    assign count_last = (count == packet_addr_t'(1));  // final cycle of a phase

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            count <= '0;
        end
        else if (count_load)
        begin
            count <= count_value;
        end
        else if (count != '0)
        begin
            count <= count - packet_addr_t'(1);          // parks at zero
        end
    end

endmodule

`default_nettype wire

// ==== src/tx_frame_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_frame_fsm
(
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     frame_pending,
    input  eth_tx_pkg::packet_addr_t frame_length,
    input  eth_tx_pkg::byte_t        tx_byte,
    input  eth_tx_pkg::byte_t        fcs_byte,
    input  logic                     count_last,
    output eth_tx_pkg::packet_addr_t tx_address,
    output logic                     frame_sent,
    output logic                     crc_clear,
    output logic                     crc_update,
    output logic                     crc_shift,
    output logic                     count_load,
    output eth_tx_pkg::packet_addr_t count_value,
    output eth_tx_pkg::byte_t        gmii_txd,
    output logic                     gmii_tx_en
);
    import eth_tx_pkg::*;

    logic [STATE_BITS-1:0] state;               // phase of the byte on the line
    logic [STATE_BITS-1:0] state_d;
    byte_t                 txd_d;
    logic                  tx_en_d;
    logic                  addr_clear;
    logic                  send_data;            // next line byte comes from the buffer
    logic                  enter_fcs;

    // ----------------------------------------
    // next phase and byte source
    // ----------------------------------------
    always_comb
    begin
        state_d     = state;
        txd_d       = 8'h00;
        tx_en_d     = 1'b0;
        addr_clear  = 1'b0;
        send_data   = 1'b0;
        enter_fcs   = 1'b0;
        frame_sent  = 1'b0;
        crc_clear   = 1'b0;
        crc_update  = 1'b0;
        crc_shift   = 1'b0;
        count_load  = 1'b0;
        count_value = '0;

        case (state)
            ST_IDLE:
            begin
                if (frame_pending)
                begin
                    state_d     = ST_PREAMBLE;
                    count_load  = 1'b1;
                    count_value = packet_addr_t'(PREAMBLE_LEN);
                    crc_clear   = 1'b1;
                    addr_clear  = 1'b1;
                    txd_d       = PREAMBLE_BYTE;
                    tx_en_d     = 1'b1;
                end
            end
            ST_PREAMBLE:
            begin
                tx_en_d = 1'b1;
                if (count_last)
                begin
                    state_d = ST_SFD;
                    txd_d   = SFD_BYTE;
                end
                else
                begin
                    txd_d = PREAMBLE_BYTE;
                end
            end
            ST_SFD:
            begin
                if (frame_length == '0)
                begin
                    enter_fcs = 1'b1;           // empty frame, no data phase
                end
                else
                begin
                    state_d     = ST_DATA;
                    count_load  = 1'b1;
                    count_value = frame_length;
                    send_data   = 1'b1;
                end
            end
            ST_DATA:
            begin
                if (count_last)
                begin
                    enter_fcs = 1'b1;
                end
                else
                begin
                    send_data = 1'b1;
                end
            end
            ST_FCS:
            begin
                if (count_last)
                begin
                    state_d     = ST_GAP;       // line drops here
                    frame_sent  = 1'b1;
                    count_load  = 1'b1;
                    count_value = packet_addr_t'(IFG_LEN);
                end
                else
                begin
                    tx_en_d   = 1'b1;
                    txd_d     = fcs_byte;
                    crc_shift = 1'b1;
                end
            end
            ST_GAP:
            begin
                if (count_last)
                begin
                    state_d = ST_IDLE;
                end
            end
            default:
            begin
                state_d = ST_IDLE;
            end
        endcase

        if (send_data)
        begin
            tx_en_d    = 1'b1;
            txd_d      = tx_byte;
            crc_update = 1'b1;                  // crc sees the same byte as the line
        end

        if (enter_fcs)
        begin
            state_d     = ST_FCS;
            count_load  = 1'b1;
            count_value = packet_addr_t'(FCS_LEN);
            tx_en_d     = 1'b1;
            txd_d       = fcs_byte;
            crc_shift   = 1'b1;
        end
    end

    // ----------------------------------------
    // registered line and read address
    // ----------------------------------------
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state      <= ST_IDLE;
            gmii_txd   <= 8'h00;
            gmii_tx_en <= 1'b0;
            tx_address <= '0;
        end
        else
        begin
            state      <= state_d;
            gmii_txd   <= txd_d;
            gmii_tx_en <= tx_en_d;
            if (addr_clear)
            begin
                tx_address <= '0;
            end
            else if (send_data && (tx_address + packet_addr_t'(1) < frame_length))
            begin
                tx_address <= tx_address + packet_addr_t'(1);  // stays on last byte
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clock_gen
(
    output logic clock,
    output logic reset
);

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;              // 10 ns period
    end

    initial
    begin
        reset = 1'b1;
        repeat (10) @(posedge clock);
        reset <= 1'b0;                          // released on a rising edge
    end

endmodule

`default_nettype wire

// ==== testbench/eth_tx_stim.txt ====
# W address(hex) value(hex) result | L length | N result
# F count then data and FCS bytes (hex) | B commits then FCS of an empty frame (hex)
# first frame is the CRC-32 check string 123456789
W 000 31 0
W 001 32 0
W 002 33 0
W 003 34 0
W 004 35 0
W 005 36 0
W 006 37 0
W 007 38 0
W 008 39 0
L 9
F 13 31 32 33 34 35 36 37 38 39 26 39 F4 CB
N 0
L 0
# second frame is built while the first one is on the line
W 002 63 0
W 000 61 0
W 001 62 0
W 192 EE 1
L 3
F 7 61 62 63 C2 41 24 35
N 0
L 0
# empty commits fill the ring faster than it drains
B 40 00 00 00 00

// ==== testbench/tb_eth_tx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eth_tx_mac;
    import eth_tx_pkg::*;

    localparam string STIM_FILE = "testbench/eth_tx_stim.txt";

    logic         clock;
    logic         reset;
    logic         op_start;
    op_t          op_code;
    packet_addr_t op_address;
    byte_t        op_value;
    logic         op_done;
    logic [16:0]  op_result;
    byte_t        gmii_txd;
    logic         gmii_tx_en;

    byte_t rec_kind [$];                        // parsed records
    int    rec_a [$];
    int    rec_b [$];
    int    rec_c [$];
    byte_t frame_data [$];                      // byte lists of F and B records
    byte_t exp_bytes [$];                       // expected frames in commit order
    int    exp_lens [$];
    byte_t rx_bytes [$];                        // frame being collected

    int   pass_count;
    int   fail_count;
    int   commits_ok;
    int   frames_seen;
    int   watchdog_cycles;
    int   gap_count;
    int   frame_gap;
    logic frame_early;
    logic in_frame;

    clock_gen clock_gen0
    (
        .clock (clock),
        .reset (reset)
    );

    eth_tx_mac dut0
    (
        .clock      (clock),
        .reset      (reset),
        .op_start   (op_start),
        .op_code    (op_code),
        .op_address (op_address),
        .op_value   (op_value),
        .op_done    (op_done),
        .op_result  (op_result),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en)
    );

    function automatic void finish_test(input string name, input logic ok);
        if (ok)
        begin
            pass_count++;
            $display("test %s: ok", name);
        end
        else
        begin
            fail_count++;
            $display("test %s: FAILED", name);
        end
    endfunction

    function automatic logic check_result(input string what, input logic [16:0] result,
                                          input logic answered, input int expected);
        if (!answered)
        begin
            $display("%s got no op_done at %0t ns", what, $time);
            return 1'b0;
        end
        if (result != 17'(expected))
        begin
            $display("MISMATCH at %0t ns: %s returned %0d, expected %0d",
                     $time, what, result, expected);
            return 1'b0;
        end
        return 1'b1;
    endfunction

    function automatic void push_expected(input int first, input int len);
        int k;
        for (k = 0; k < len; k++)
        begin
            exp_bytes.push_back(frame_data[first + k]);
        end
        exp_lens.push_back(len);
    endfunction

    // ----------------------------------------
    // frame monitor
    // ----------------------------------------
    function automatic void check_frame();
        int    exp_len;
        int    k;
        logic  ok;
        byte_t want;
        ok = 1'b1;
        frames_seen++;
        if (frame_early)
        begin
            $display("frame %0d started at %0t ns with no commit left for it", frames_seen, $time);
            ok = 1'b0;
        end
        if (frames_seen > 1 && frame_gap < IFG_LEN)
        begin
            $display("MISMATCH at %0t ns: gap before frame %0d is %0d cycles, expected >= %0d",
                     $time, frames_seen, frame_gap, IFG_LEN);
            ok = 1'b0;
        end
        if (exp_lens.size() == 0)
        begin
            $display("frame %0d of %0d bytes arrived but none was expected", frames_seen,
                     rx_bytes.size());
            ok = 1'b0;
        end
        else
        begin
            exp_len = exp_lens.pop_front();
            if (rx_bytes.size() != PREAMBLE_LEN + 1 + exp_len)
            begin
                $display("MISMATCH at %0t ns: frame %0d lasted %0d cycles, expected %0d",
                         $time, frames_seen, rx_bytes.size(), PREAMBLE_LEN + 1 + exp_len);
                ok = 1'b0;
            end
            for (k = 0; k < PREAMBLE_LEN + 1 + exp_len; k++)
            begin
                if (k < PREAMBLE_LEN)
                    want = PREAMBLE_BYTE;
                else if (k == PREAMBLE_LEN)
                    want = SFD_BYTE;
                else
                    want = exp_bytes.pop_front();
                if (k < rx_bytes.size() && rx_bytes[k] != want)
                begin
                    $display("MISMATCH at %0t ns: frame %0d byte %0d is %02h, expected %02h",
                             $time, frames_seen, k, rx_bytes[k], want);
                    ok = 1'b0;
                end
            end
        end
        rx_bytes.delete();
        finish_test($sformatf("frame %0d", frames_seen), ok);
    endfunction

    always @(negedge clock)
    begin
        if (reset)
        begin
            in_frame  = 1'b0;
            gap_count = 0;
        end
        else if (gmii_tx_en)
        begin
            if (!in_frame)
            begin
                in_frame    = 1'b1;
                frame_gap   = gap_count;
                frame_early = (frames_seen >= commits_ok);  // every frame needs its commit
            end
            rx_bytes.push_back(gmii_txd);
        end
        else if (in_frame)
        begin
            in_frame  = 1'b0;
            gap_count = 1;                      // first low cycle of the gap
            check_frame();
        end
        else
        begin
            gap_count++;
        end
    end

    // ----------------------------------------
    // host operations
    // ----------------------------------------
    task automatic run_op(input op_t code, input packet_addr_t addr, input byte_t value,
                          output logic [16:0] result, output logic answered);
        @(posedge clock);
        op_start   <= 1'b1;
        op_code    <= code;
        op_address <= addr;
        op_value   <= value;
        @(posedge clock);
        op_start <= 1'b0;
        @(negedge clock);                       // answer is due one cycle after the strobe
        answered = op_done;
        result   = op_result;
    endtask

    task automatic wait_line_idle();
        int quiet;
        quiet = 0;
        while (quiet < 3 * IFG_LEN)             // longer than any gap between frames
        begin
            @(negedge clock);
            if (gmii_tx_en)
                quiet = 0;
            else
                quiet++;
        end
    endtask

    task automatic check_reset_quiet();
        int   k;
        logic ok;
        ok = 1'b1;
        for (k = 0; k < 2 * IFG_LEN; k++)
        begin
            @(negedge clock);
            if (gmii_tx_en || op_done)
            begin
                $display("MISMATCH at %0t ns: gmii_tx_en %b op_done %b after reset",
                         $time, gmii_tx_en, op_done);
                ok = 1'b0;
            end
        end
        finish_test("idle after reset", ok);
    endtask

    task automatic overflow_burst(input int first, input int count);
        int          i;
        int          overflows;
        logic [16:0] result;
        logic        answered;
        logic        ok;
        ok        = 1'b1;
        overflows = 0;
        for (i = 0; i < count; i++)
        begin
            run_op(OP_WRITE_NEXT, '0, '0, result, answered);
            if (!answered)
            begin
                $display("burst commit %0d got no op_done at %0t ns", i, $time);
                ok = 1'b0;
            end
            else if (result == 17'd0)
            begin
                push_expected(first, FCS_LEN);
                commits_ok++;
            end
            else if (result == 17'd1)
            begin
                overflows++;
            end
            else
            begin
                $display("MISMATCH at %0t ns: burst commit returned %0d", $time, result);
                ok = 1'b0;
            end
        end
        if (overflows == 0)
        begin
            $display("MISMATCH at %0t ns: %0d commits saw no overflow", $time, count);
            ok = 1'b0;
        end
        wait_line_idle();
        if (frames_seen != commits_ok)
        begin
            $display("MISMATCH at %0t ns: %0d frames seen, %0d commits accepted",
                     $time, frames_seen, commits_ok);
            ok = 1'b0;
        end
        finish_test($sformatf("burst of %0d commits", count), ok);
    endtask

    task automatic play_record(input int idx);
        logic [16:0] result;
        logic        answered;
        logic        ok;
        case (rec_kind[idx])
            "W":
            begin
                run_op(OP_WRITE, packet_addr_t'(rec_a[idx]), byte_t'(rec_b[idx]),
                       result, answered);
                ok = check_result("write", result, answered, rec_c[idx]);
                finish_test($sformatf("write %03h", rec_a[idx]), ok);
            end
            "L":
            begin
                run_op(OP_WRITE_LEN, '0, '0, result, answered);
                ok = check_result("length query", result, answered, rec_a[idx]);
                finish_test("length query", ok);
            end
            "N":
            begin
                run_op(OP_WRITE_NEXT, '0, '0, result, answered);
                if (answered && result == 17'd0)
                    commits_ok++;
                ok = check_result("commit", result, answered, rec_a[idx]);
                finish_test("commit", ok);
            end
            "F":
            begin
                push_expected(rec_a[idx], rec_b[idx]);
            end
            default:
            begin
                overflow_burst(rec_a[idx], rec_b[idx]);
            end
        endcase
    endtask

    // ----------------------------------------
    // stimulus file
    // ----------------------------------------
    task automatic read_stimulus(output logic ok);
        int               fd;
        int               got;
        int               a;
        int               b;
        int               c;
        int               k;
        byte_t            kind;
        logic [8*200-1:0] rest;
        ok = 1'b1;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0)
        begin
            $display("stimulus file %s could not be opened", STIM_FILE);
            ok = 1'b0;
        end
        else
        begin
            got = $fscanf(fd, "%s", kind);
            while (got == 1 && ok)
            begin
                a = 0;
                b = 0;
                c = 0;
                if (kind == "#")
                    got = $fgets(rest, fd);     // comment runs to end of line
                else if (kind == "W")
                    got = $fscanf(fd, "%h %h %d", a, b, c);
                else if (kind == "L" || kind == "N")
                    got = $fscanf(fd, "%d", a);
                else if (kind == "F" || kind == "B")
                begin
                    got = $fscanf(fd, "%d", b);
                    a   = frame_data.size();
                    for (k = 0; k < ((kind == "F") ? b : FCS_LEN); k++)
                    begin
                        got = $fscanf(fd, "%h", c);
                        frame_data.push_back(byte_t'(c));
                    end
                end
                else
                begin
                    $display("stimulus file holds an unknown record kind '%c'", kind);
                    ok = 1'b0;
                end
                if (kind != "#" && ok)
                begin
                    rec_kind.push_back(kind);
                    rec_a.push_back(a);
                    rec_b.push_back(b);
                    rec_c.push_back(c);
                end
                got = $fscanf(fd, "%s", kind);
            end
            $fclose(fd);
        end
    endtask

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial
    begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clock);
        $display("timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display(">>> FAIL");
        $finish;
    end

    initial
    begin
        logic ok;
        int   idx;
        int   frame_total;
        op_start    = 1'b0;
        op_code     = OP_WRITE;
        op_address  = '0;
        op_value    = '0;
        pass_count  = 0;
        fail_count  = 0;
        commits_ok  = 0;
        frames_seen = 0;
        gap_count   = 0;
        frame_gap   = 0;
        frame_early = 1'b0;
        in_frame    = 1'b0;
        watchdog_cycles = 0;

        read_stimulus(ok);
        if (!ok)
        begin
            fail_count++;
        end
        else
        begin
            frame_total = 0;
            for (idx = 0; idx < rec_kind.size(); idx++)
            begin
                if (rec_kind[idx] == "F")
                    frame_total++;
                else if (rec_kind[idx] == "B")
                    frame_total += rec_b[idx];  // every burst commit may send a frame
            end
            watchdog_cycles = 40 * rec_kind.size() + 500 * frame_total;

            @(negedge clock);
            while (reset)
            begin
                @(negedge clock);
            end
            check_reset_quiet();
            for (idx = 0; idx < rec_kind.size(); idx++)
            begin
                play_record(idx);
            end
            wait_line_idle();
            ok = (exp_lens.size() == 0) && (frames_seen == commits_ok);
            if (!ok)
            begin
                $display("MISMATCH at %0t ns: %0d expected frames never sent, %0d of %0d seen",
                         $time, exp_lens.size(), frames_seen, commits_ok);
            end
            finish_test("all committed frames sent", ok);
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
